// ==== Makefile ====
# Verilator build and run for the instruction buffer testbench.

VERILATOR ?= verilator
TOP       ?= frontend_ibuf_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK
FAIL_MSG  ?= Something failed

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
rtl/ibuf_pkg.sv
rtl/predecoder.sv
rtl/inst_buffer_bank.sv
rtl/inst_buffer.sv
rtl/frontend_ibuf_top.sv
test/tb_clock_gen.sv
test/inst_buffer_props.sv
test/frontend_ibuf_tb.sv

// ==== rtl/frontend_ibuf_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module frontend_ibuf_top
    import ibuf_pkg::*;
#(
    parameter int fetch_width = fetch_width_default,
    parameter int bank_depth  = bank_depth_default
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          fetch_valid,
    input  fetch_block_t  fetch_blk,
    output logic          fetch_ready,
    input  logic          decode_ready,
    output fetch_bundle_t bundle
);

    pd_packet_t pd_pkt;   // Registered predecoder output.
    logic       buf_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Predecode stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    predecoder #(
        .fetch_width (fetch_width)
    ) u_predecoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_valid (fetch_valid),
        .blk       (fetch_blk),
        .accept    (fetch_ready),
        .pkt       (pd_pkt)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    inst_buffer #(
        .fetch_width (fetch_width),
        .bank_depth  (bank_depth)
    ) u_inst_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .pkt          (pd_pkt),
        .decode_ready (decode_ready),
        .bundle       (bundle),
        .full         (buf_full)
    );

    assign fetch_ready = ~buf_full;  // Independent of fetch_valid.

endmodule

`default_nettype wire

// ==== rtl/ibuf_pkg.sv ====
`default_nettype none

package ibuf_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and default sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int xlen_w              = 32;
    localparam int fetch_width_default = 4;
    localparam int bank_depth_default  = 4;   // Entries per bank.
    localparam int fsq_idx_w           = 6;

    localparam int off_w = $clog2(fetch_width_default);      // Slot index in a block.
    localparam int num_w = $clog2(fetch_width_default + 1);  // Slot count, zero included.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // RV32 major opcodes that change control flow.
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        kind_plain,
        kind_branch,   // Conditional branch.
        kind_jal,      // Direct jump.
        kind_jalr      // Indirect jump.
    } inst_kind_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Structures crossing module boundaries
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Aligned block from the fetch unit.
    typedef struct packed {
        logic [fsq_idx_w-1:0]                       fsq_idx;
        logic [off_w-1:0]                           start_off;  // First useful slot.
        logic [fetch_width_default-1:0][xlen_w-1:0] inst;
    } fetch_block_t;

    typedef struct packed {
        logic [fsq_idx_w-1:0] fsq_idx;
        logic [off_w-1:0]     offset;   // Slot it held in the fetch block.
        inst_kind_e           kind;
        logic [xlen_w-1:0]    inst;
    } ibuf_entry_t;

    // Predecoder output, packed to the low slots.
    typedef struct packed {
        logic [fetch_width_default-1:0]              en;
        logic [num_w-1:0]                            num;
        ibuf_entry_t [fetch_width_default-1:0]       slot;
    } pd_packet_t;

    // Buffer output to decode, oldest word in slot 0.
    typedef struct packed {
        logic [fetch_width_default-1:0]              en;
        ibuf_entry_t [fetch_width_default-1:0]       slot;
    } fetch_bundle_t;

endpackage

`default_nettype wire

// ==== rtl/inst_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_buffer
    import ibuf_pkg::*;
#(
    parameter int fetch_width = fetch_width_default,
    parameter int bank_depth  = bank_depth_default
) (
    input  logic          clk,
    input  logic          rst_n,
    input  pd_packet_t    pkt,
    input  logic          decode_ready,
    output fetch_bundle_t bundle,
    output logic          full
);

    localparam int bank_w   = $clog2(fetch_width);
    localparam int idx_w    = $clog2(bank_depth);
    localparam int capacity = fetch_width * bank_depth;
    localparam int cnt_w    = $clog2(capacity + 1);

    // Global pointers. head and tail select a bank.
    logic [bank_w-1:0] head;
    logic [bank_w-1:0] tail;
    logic [cnt_w-1:0]  count;

    // Per-bank entry pointers.
    logic [idx_w-1:0]  widx [fetch_width];
    logic [idx_w-1:0]  ridx [fetch_width];

    logic [fetch_width-1:0]        bank_we;
    logic [fetch_width-1:0]        bank_re;
    ibuf_entry_t                   bank_din  [fetch_width];
    ibuf_entry_t                   bank_dout [fetch_width];

    logic [fetch_width-1:0]        out_en;
    ibuf_entry_t [fetch_width-1:0] rd_slot;
    logic [cnt_w-1:0]              avail;
    logic [cnt_w-1:0]              out_num;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Banks with rotated write and read selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar b = 0; b < fetch_width; b++) begin : g_bank
        logic [bank_w-1:0] wslot;  // Packet slot landing in this bank.
        logic [bank_w-1:0] rslot;  // Bundle slot fed by this bank.

        assign wslot       = bank_w'(b) - tail;
        assign rslot       = bank_w'(b) - head;
        assign bank_we[b]  = pkt.en[wslot];
        assign bank_din[b] = pkt.slot[wslot];
        assign bank_re[b]  = decode_ready && out_en[rslot];

        inst_buffer_bank #(
            .depth (bank_depth)
        ) u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (bank_we[b]),
            .waddr (widx[b]),
            .din   (bank_din[b]),
            .raddr (ridx[b]),
            .dout  (bank_dout[b])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output bundle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < fetch_width; i++) begin : g_rd
        assign out_en[i]  = (count > cnt_w'(i));  // Thermometer of occupancy.
        assign rd_slot[i] = bank_dout[bank_w'(head + bank_w'(i))];
    end

    assign avail   = (count >= cnt_w'(fetch_width)) ? cnt_w'(fetch_width) : count;
    assign out_num = decode_ready ? avail : '0;

    assign bundle = '{en: out_en, slot: rd_slot};

    // Room kept for one packet in the predecoder and one still to be accepted.
    assign full = (count > cnt_w'(capacity - 2 * fetch_width));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointer and occupancy update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int b = 0; b < fetch_width; b++) begin
                widx[b] <= '0;
                ridx[b] <= '0;
            end
        end else begin
            head  <= head + bank_w'(out_num);
            tail  <= tail + bank_w'(pkt.num);
            count <= count + cnt_w'(pkt.num) - out_num;
            for (int b = 0; b < fetch_width; b++) begin
                if (bank_we[b]) begin
                    widx[b] <= widx[b] + 1'b1;
                end
                if (bank_re[b]) begin
                    ridx[b] <= ridx[b] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/inst_buffer_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_buffer_bank
    import ibuf_pkg::*;
#(
    parameter int depth = bank_depth_default
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  ibuf_entry_t              din,
    input  logic [$clog2(depth)-1:0] raddr,
    output ibuf_entry_t              dout
);

    ibuf_entry_t mem [depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= din;
        end
    end

    assign dout = mem[raddr];  // Asynchronous read.

endmodule

`default_nettype wire

// ==== rtl/predecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module predecoder
    import ibuf_pkg::*;
#(
    parameter int fetch_width = fetch_width_default
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         blk_valid,
    input  fetch_block_t blk,
    input  logic         accept,
    output pd_packet_t   pkt
);

    logic                         take;
    inst_kind_e                   kind [fetch_width];
    logic [fetch_width-1:0]       nxt_en;
    logic [num_w-1:0]             nxt_num;
    ibuf_entry_t [fetch_width-1:0] nxt_slot;

    logic [fetch_width-1:0]       en_q;
    logic [num_w-1:0]             num_q;
    ibuf_entry_t [fetch_width-1:0] slot_q;

    assign take = blk_valid && accept;  // Block handshake.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Classify every slot
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int j = 0; j < fetch_width; j++) begin
            case (opcode_e'(blk.inst[j][6:0]))
                op_branch: kind[j] = kind_branch;
                op_jal:    kind[j] = kind_jal;
                op_jalr:   kind[j] = kind_jalr;
                default:   kind[j] = kind_plain;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Trim and pack
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        int   wr;     // Next free packed slot.
        logic ended;  // A jump was already kept.
        nxt_en   = '0;
        nxt_slot = '0;
        wr       = 0;
        ended    = 1'b0;
        for (int j = 0; j < fetch_width; j++) begin
            if (!ended && j >= int'(blk.start_off)) begin
                nxt_slot[wr] = '{fsq_idx: blk.fsq_idx,
                                 offset:  off_w'(j),
                                 kind:    kind[j],
                                 inst:    blk.inst[j]};
                nxt_en[wr]   = 1'b1;
                wr           = wr + 1;
                ended        = (kind[j] == kind_jal) || (kind[j] == kind_jalr);
            end
        end
        nxt_num = num_w'(wr);
    end

    // Control part of the packet.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q  <= '0;
            num_q <= '0;
        end else begin
            en_q  <= take ? nxt_en : '0;
            num_q <= take ? nxt_num : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            slot_q <= nxt_slot;  // Only meaningful under en.
        end
    end

    assign pkt = '{en: en_q, num: num_q, slot: slot_q};

endmodule

`default_nettype wire

// ==== test/frontend_ibuf_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module frontend_ibuf_tb
    import ibuf_pkg::*;
();

    localparam int fetch_width   = fetch_width_default;
    localparam int bank_depth    = bank_depth_default;
    localparam int capacity      = fetch_width * bank_depth;
    localparam int full_level    = capacity - 2 * fetch_width;  // Above this fetch stalls.
    localparam int row_timeout   = 64;
    localparam int drain_timeout = 100;
    localparam int random_rows   = 300;

    localparam logic [6:0] opc_addi   = 7'h13;
    localparam logic [6:0] opc_lw     = 7'h03;
    localparam logic [6:0] opc_branch = 7'h63;
    localparam logic [6:0] opc_jal    = 7'h6f;
    localparam logic [6:0] opc_jalr   = 7'h67;

    typedef struct packed {
        logic         valid;
        fetch_block_t blk;
        logic [7:0]   dr_pat;  // decode_ready per cycle while the row is shown.
    } row_t;

    logic          clk;
    logic          rst_n;
    logic          fetch_valid;
    fetch_block_t  fetch_blk;
    logic          fetch_ready;
    logic          decode_ready;
    fetch_bundle_t bundle;

    row_t          rows [$];
    ibuf_entry_t   exp_q [$];   // Words the buffer should hold.
    ibuf_entry_t   pend_q [$];  // Words in the predecoder register.

    int            errors;
    int            checks;
    int            delivered;
    int            stall_cycles;
    int            assert_fails;
    logic          timed_out;
    logic          checking;

    tb_clock_gen #(.half_period(4)) u_clk (.clk(clk));

    frontend_ibuf_top #(
        .fetch_width (fetch_width),
        .bank_depth  (bank_depth)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_blk    (fetch_blk),
        .fetch_ready  (fetch_ready),
        .decode_ready (decode_ready),
        .bundle       (bundle)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] make_word(input logic [6:0] opc, input logic [24:0] body);
        return {body, opc};
    endfunction

    function automatic inst_kind_e classify_word(input logic [31:0] w);
        case (w[6:0])
            opc_branch: return kind_branch;
            opc_jal:    return kind_jal;
            opc_jalr:   return kind_jalr;
            default:    return kind_plain;
        endcase
    endfunction

    task automatic add_row(input logic valid, input logic [5:0] fsq, input logic [1:0] start,
                           input logic [6:0] o0, o1, o2, o3, input logic [7:0] dr_pat);
        row_t       r;
        logic [6:0] opc [4];
        opc[0] = o0;
        opc[1] = o1;
        opc[2] = o2;
        opc[3] = o3;
        r.valid         = valid;
        r.blk.fsq_idx   = fsq;
        r.blk.start_off = start;
        r.dr_pat        = dr_pat;
        for (int j = 0; j < fetch_width; j++) begin
            r.blk.inst[j] = make_word(opc[j], {fsq, 2'(j), 17'h0b5a1});  // Unique per slot.
        end
        rows.push_back(r);
    endtask

    task automatic add_random_row();
        row_t       r;
        logic [6:0] opc;
        r.valid         = ($urandom_range(9) != 0);
        r.blk.fsq_idx   = 6'($urandom);
        r.blk.start_off = ($urandom_range(1) == 0) ? 2'd0 : 2'($urandom);
        r.dr_pat        = 8'($urandom);
        for (int j = 0; j < fetch_width; j++) begin
            case ($urandom_range(7))
                0:       opc = opc_branch;
                1:       opc = opc_jal;
                2:       opc = opc_jalr;
                3:       opc = opc_lw;
                default: opc = opc_addi;
            endcase
            r.blk.inst[j] = make_word(opc, 25'($urandom));
        end
        rows.push_back(r);
    endtask

    // Trim, stop after the first jump, pack low.
    task automatic push_expected(input fetch_block_t b);
        ibuf_entry_t e;
        logic        stop;
        stop = 1'b0;
        for (int j = int'(b.start_off); j < fetch_width; j++) begin
            if (!stop) begin
                e.fsq_idx = b.fsq_idx;
                e.offset  = off_w'(j);
                e.kind    = classify_word(b.inst[j]);
                e.inst    = b.inst[j];
                pend_q.push_back(e);
                stop = (e.kind == kind_jal) || (e.kind == kind_jalr);
            end
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic build_table();
        // Full plain blocks.
        add_row(1'b1, 6'd1, 2'd0, opc_addi, opc_addi, opc_lw, opc_addi, 8'hff);
        add_row(1'b1, 6'd2, 2'd0, opc_addi, opc_addi, opc_addi, opc_addi, 8'hff);
        add_row(1'b1, 6'd3, 2'd0, opc_lw, opc_addi, opc_addi, opc_lw, 8'hff);
        add_row(1'b0, 6'd0, 2'd0, opc_addi, opc_addi, opc_addi, opc_addi, 8'hff);
        // Start offsets.
        add_row(1'b1, 6'd4, 2'd1, opc_addi, opc_lw, opc_addi, opc_addi, 8'hff);
        add_row(1'b1, 6'd5, 2'd2, opc_addi, opc_addi, opc_lw, opc_addi, 8'hff);
        add_row(1'b1, 6'd6, 2'd3, opc_addi, opc_addi, opc_addi, opc_lw, 8'hff);
        add_row(1'b1, 6'd7, 2'd0, opc_addi, opc_addi, opc_addi, opc_addi, 8'haa);
        // Jumps end the block.
        add_row(1'b1, 6'd8, 2'd0, opc_addi, opc_jal, opc_addi, opc_addi, 8'hff);
        add_row(1'b1, 6'd9, 2'd0, opc_jalr, opc_addi, opc_addi, opc_addi, 8'hff);
        add_row(1'b1, 6'd10, 2'd0, opc_branch, opc_addi, opc_branch, opc_jal, 8'hff);
        add_row(1'b1, 6'd11, 2'd2, opc_jalr, opc_addi, opc_branch, opc_jal, 8'hff);
        add_row(1'b1, 6'd12, 2'd1, opc_addi, opc_branch, opc_jalr, opc_jal, 8'h0f);
        add_row(1'b0, 6'd0, 2'd0, opc_addi, opc_addi, opc_addi, opc_addi, 8'hff);
        // Decode stalls long enough to fill the buffer.
        for (int f = 20; f < 26; f++) begin
            add_row(1'b1, 6'(f), 2'd0, opc_addi, opc_lw, opc_addi, opc_addi, 8'h00);
        end
        add_row(1'b0, 6'd0, 2'd0, opc_addi, opc_addi, opc_addi, opc_addi, 8'hff);
        for (int r = 0; r < random_rows; r++) begin
            add_random_row();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Called on a rising edge. Valid rows stay until accepted, idle rows last 8 cycles.
    task automatic apply_row(input row_t r);
        int   k;
        logic done;
        k    = 0;
        done = 1'b0;
        while (!done && !timed_out) begin
            fetch_valid  <= r.valid;
            fetch_blk    <= r.blk;
            decode_ready <= (k < 8) ? r.dr_pat[k] : 1'b1;
            @(negedge clk);
            done = r.valid ? fetch_ready : (k == 7);
            @(posedge clk);
            k++;
            if (!done && k > row_timeout) begin
                errors++;
                timed_out = 1'b1;
                $display("Timeout: block with fsq_idx %0d not accepted within %0d cycles",
                         r.blk.fsq_idx, row_timeout);
            end
        end
    endtask

    task automatic drain_buffer();
        int waited;
        waited = 0;
        fetch_valid  <= 1'b0;
        decode_ready <= 1'b1;
        while ((exp_q.size() != 0 || pend_q.size() != 0) && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > drain_timeout) begin
                errors++;
                timed_out = 1'b1;
                $display("Timeout: buffer still holds words after %0d cycles of draining",
                         drain_timeout);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitor. Outputs are sampled mid-cycle, the model steps for the next edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        int          n;
        logic [31:0] exp_en;
        if (checking) begin
            n      = (exp_q.size() < fetch_width) ? exp_q.size() : fetch_width;
            exp_en = (32'd1 << n) - 32'd1;
            compare_value("bundle.en", 32'(bundle.en), exp_en);
            compare_value("fetch_ready", 32'(fetch_ready), 32'(exp_q.size() <= full_level));
            for (int i = 0; i < n; i++) begin
                compare_value($sformatf("bundle.slot[%0d].fsq_idx", i),
                               32'(bundle.slot[i].fsq_idx), 32'(exp_q[i].fsq_idx));
                compare_value($sformatf("bundle.slot[%0d].offset", i),
                              32'(bundle.slot[i].offset), 32'(exp_q[i].offset));
                compare_value($sformatf("bundle.slot[%0d].kind", i),
                              32'(bundle.slot[i].kind), 32'(exp_q[i].kind));
                compare_value($sformatf("bundle.slot[%0d].inst", i),
                              bundle.slot[i].inst, exp_q[i].inst);
            end
            if (!fetch_ready) begin
                stall_cycles++;
            end
            if (decode_ready) begin
                for (int i = 0; i < n; i++) begin
                    void'(exp_q.pop_front());
                end
                delivered += n;
            end
            while (pend_q.size() > 0) begin
                exp_q.push_back(pend_q.pop_front());  // Written at the next edge.
            end
            if (fetch_valid && fetch_ready) begin
                push_expected(fetch_blk);
            end
            if (exp_q.size() > capacity) begin
                errors++;
                $display("Error at %0d ns: %0d words queued, more than the capacity of %0d",
                         $time, exp_q.size(), capacity);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(68880));
        errors       = 0;
        checks       = 0;
        delivered    = 0;
        stall_cycles = 0;
        assert_fails = 0;
        timed_out    = 1'b0;
        checking     = 1'b0;
        rst_n        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_blk    = '0;
        decode_ready = 1'b0;
        build_table();

        repeat (8) @(posedge clk);
        rst_n    <= 1'b1;
        checking <= 1'b1;
        @(negedge clk);
        compare_value("bundle.en after reset", 32'(bundle.en), 32'd0);
        compare_value("fetch_ready after reset", 32'(fetch_ready), 32'd1);
        @(posedge clk);

        for (int r = 0; r < rows.size() && !timed_out; r++) begin
            apply_row(rows[r]);
        end
        drain_buffer();
        @(negedge clk);
        compare_value("bundle.en after drain", 32'(bundle.en), 32'd0);
        if (stall_cycles == 0) begin
            errors++;
            $display("fetch_ready never fell although decode was stalled");
        end

        assert_fails = UUT.u_inst_buffer.u_props.failures;
        $display("Checks: %0d, words delivered: %0d, errors: %0d, assertion failures: %0d",
                 checks, delivered, errors, assert_fails);
        if (errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/inst_buffer_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_buffer_props #(
    parameter int fetch_width = 4,
    parameter int capacity    = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [$clog2(capacity + 1)-1:0]   count,
    input  logic [fetch_width-1:0]            en,
    input  logic                              full
);

    localparam int cnt_w = $clog2(capacity + 1);

    int failures = 0;

    a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
        count <= cnt_w'(capacity))
        else begin
            failures++;
            $error("Occupancy %0d above capacity %0d.", count, capacity);
        end

    // A thermometer mask plus one has no bit in common with itself.
    a_en_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        ((en + fetch_width'(1)) & en) == '0)
        else begin
            failures++;
            $error("Bundle en %b is not contiguous from slot 0.", en);
        end

    a_full_in_reset: assert property (@(posedge clk) !rst_n |-> !full)
        else begin
            failures++;
            $error("full is high during reset.");
        end

endmodule

bind inst_buffer inst_buffer_props #(
    .fetch_width (fetch_width),
    .capacity    (capacity)
) u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .count (count),
    .en    (bundle.en),
    .full  (full)
);

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period = 4  // In ns.
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
